//--- Makefile
# Verilator build and run of the video subsystem testbench
# Any variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= tb_vic_video
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Some tests failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A crashed simulator counts as a failure in the log
test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation finished, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/vic_pkg.sv
// ====================================================================
// Video timing defaults, page address modes and the structs shared
// by the timing generator, the address multiplexer and the top level
// ====================================================================

package vic_pkg;

	// Horizontal raster in pixel steps
	// Line runs 0 to H_TOTAL, so 328 steps per line
	localparam logic [8:0] H_TOTAL_DEF       = 9'd327;
	// Blank rises on the step out of this count
	localparam logic [8:0] H_BLANK_START_DEF = 9'd255;
	// Sync window edges, also the line step point for the vertical count
	localparam logic [8:0] H_SYNC_START_DEF  = 9'd272;
	localparam logic [8:0] H_SYNC_END_DEF    = 9'd304;

	// Vertical raster in lines
	// Frame runs 0 to V_TOTAL, so 263 lines per frame
	localparam logic [8:0] V_TOTAL_DEF       = 9'd262;
	localparam logic [8:0] V_BLANK_START_DEF = 9'd224;
	// Blank drops on the line step out of this count
	localparam logic [8:0] V_BLANK_END_DEF   = 9'd0;
	localparam logic [8:0] V_SYNC_START_DEF  = 9'd236;
	localparam logic [8:0] V_SYNC_END_DEF    = 9'd240;

	// Horizontal count right after reset
	// Matches the original board, which powered up one pixel in
	localparam logic [8:0] H_COUNT_RESET     = 9'd1;

	// Page address source select, one code drives all six bits
	typedef enum logic [2:0] {
		MODE_CPU_LO    = 3'd0,
		MODE_CPU_HI    = 3'd1,
		MODE_HPOS      = 3'd2,
		MODE_VPOS      = 3'd3,
		MODE_DATA_LINE = 3'd4,
		MODE_COLUMN    = 3'd5,
		MODE_OFF6      = 3'd6,
		MODE_OFF7      = 3'd7
	} addr_mode_e;

	// Raster position and the four video flags, 22 bits
	typedef struct packed {
		logic [8:0] hcnt;
		logic [8:0] vcnt;
		logic       hsync;
		logic       vsync;
		logic       hblank;
		logic       vblank;
	} vic_timing_t;

	// CPU side of the board, 20 bits
	typedef struct packed {
		// Address bus
		logic [11:0] addr;
		// Data bus
		logic [7:0]  data;
	} cpu_bus_t;

endpackage

//--- design/vic_video.sv
// ====================================================================
// Video subsystem top, raster timing feeding the RAM page address
// ====================================================================

`timescale 1ns/1ps

module vic_video
	import vic_pkg::*;
#(
	// Raster shape, defaults give the original 328 x 263
	parameter logic [8:0] H_TOTAL       = H_TOTAL_DEF,
	parameter logic [8:0] H_BLANK_START = H_BLANK_START_DEF,
	parameter logic [8:0] H_SYNC_START  = H_SYNC_START_DEF,
	parameter logic [8:0] H_SYNC_END    = H_SYNC_END_DEF,
	parameter logic [8:0] V_TOTAL       = V_TOTAL_DEF,
	parameter logic [8:0] V_BLANK_START = V_BLANK_START_DEF,
	parameter logic [8:0] V_BLANK_END   = V_BLANK_END_DEF,
	parameter logic [8:0] V_SYNC_START  = V_SYNC_START_DEF,
	parameter logic [8:0] V_SYNC_END    = V_SYNC_END_DEF
)
(
	input  logic        clk,
	input  logic        reset,
	// Pixel strobe from the dot clock section
	input  logic        src,
	// Column latch strobe from the CPU side
	input  logic        msb,
	input  addr_mode_e  mode,
	input  cpu_bus_t    cpu,
	// Counters and flags, one clock after the strobe edge
	output vic_timing_t timing,
	output logic [5:0]  ram_addr
);

	// Raster generator
	video_timing #(
		.H_TOTAL       (H_TOTAL),
		.H_BLANK_START (H_BLANK_START),
		.H_SYNC_START  (H_SYNC_START),
		.H_SYNC_END    (H_SYNC_END),
		.V_TOTAL       (V_TOTAL),
		.V_BLANK_START (V_BLANK_START),
		.V_BLANK_END   (V_BLANK_END),
		.V_SYNC_START  (V_SYNC_START),
		.V_SYNC_END    (V_SYNC_END)
	) i_video_timing (
		.clk    (clk),
		.reset  (reset),
		.src    (src),
		.timing (timing)
	);

	// Page address select
	// Reads the same timing word that leaves the top
	vram_addr_mux i_vram_addr_mux (
		.clk      (clk),
		.reset    (reset),
		.msb      (msb),
		.mode     (mode),
		.cpu      (cpu),
		.timing   (timing),
		.ram_addr (ram_addr)
	);

endmodule

//--- design/video_timing.sv
// ====================================================================
// Pixel strobe edge detect, raster counters and sync/blank flags
// ====================================================================

`timescale 1ns/1ps

module video_timing
	import vic_pkg::*;
#(
	parameter logic [8:0] H_TOTAL       = H_TOTAL_DEF,
	parameter logic [8:0] H_BLANK_START = H_BLANK_START_DEF,
	parameter logic [8:0] H_SYNC_START  = H_SYNC_START_DEF,
	parameter logic [8:0] H_SYNC_END    = H_SYNC_END_DEF,
	parameter logic [8:0] V_TOTAL       = V_TOTAL_DEF,
	parameter logic [8:0] V_BLANK_START = V_BLANK_START_DEF,
	parameter logic [8:0] V_BLANK_END   = V_BLANK_END_DEF,
	parameter logic [8:0] V_SYNC_START  = V_SYNC_START_DEF,
	parameter logic [8:0] V_SYNC_END    = V_SYNC_END_DEF
)
(
	input  logic        clk,
	input  logic        reset,
	// Pixel strobe, one step per falling edge
	input  logic        src,
	output vic_timing_t timing
);

	// Previous strobe sample
	logic src_last;
	// One clock pulse on a strobe falling edge
	logic src_fall;
	// Horizontal count at end of line
	logic h_at_total;
	// Line step point, once per line
	logic line_step;
	// Vertical count at end of frame
	logic v_at_total;

	// Low now, high on the last clock
	assign src_fall   = !src && src_last;
	assign h_at_total = (timing.hcnt == H_TOTAL);
	// Vertical count moves at the start of horizontal sync
	assign line_step  = (timing.hcnt == H_SYNC_START);
	assign v_at_total = (timing.vcnt == V_TOTAL);

	// Edge history
	// Sampled every clock so the first edge after reset is clean
	always_ff @(posedge clk)
	begin
		src_last <= src;
	end

	// Counters and flags
	// All decisions use the count before the step
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			timing.hcnt   <= H_COUNT_RESET;
			timing.vcnt   <= 9'd0;
			timing.hsync  <= 1'b0;
			timing.vsync  <= 1'b0;
			timing.hblank <= 1'b0;
			timing.vblank <= 1'b0;
		end
		else if (src_fall)
		begin
			// Horizontal step with wrap
			if (h_at_total)
				timing.hcnt <= 9'd0;
			else
				timing.hcnt <= timing.hcnt + 9'd1;

			// Horizontal blank
			// Set entering the right border, cleared at line wrap
			if (timing.hcnt == H_BLANK_START)
				timing.hblank <= 1'b1;
			if (h_at_total)
				timing.hblank <= 1'b0;

			// Horizontal sync window
			if (line_step)
				timing.hsync <= 1'b1;
			if (timing.hcnt == H_SYNC_END)
				timing.hsync <= 1'b0;

			// Vertical side, one step per line
			if (line_step)
			begin
				if (v_at_total)
					timing.vcnt <= 9'd0;
				else
					timing.vcnt <= timing.vcnt + 9'd1;

				// Vertical blank
				// Covers the bottom border and the wrap line
				if (timing.vcnt == V_BLANK_START)
					timing.vblank <= 1'b1;
				if (timing.vcnt == V_BLANK_END)
					timing.vblank <= 1'b0;

				// Vertical sync, a few lines below the bottom
				if (timing.vcnt == V_SYNC_START)
					timing.vsync <= 1'b1;
				if (timing.vcnt == V_SYNC_END)
					timing.vsync <= 1'b0;
			end
		end
	end

endmodule

//--- design/vram_addr_mux.sv
// ====================================================================
// CPU column latch and the mode-selected video RAM page address
// ====================================================================

`timescale 1ns/1ps

module vram_addr_mux
	import vic_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	// Column latch strobe, loads on rising edge
	input  logic        msb,
	input  addr_mode_e  mode,
	input  cpu_bus_t    cpu,
	input  vic_timing_t timing,
	// Page address to the external RAM
	output logic [5:0]  ram_addr
);

	// Previous latch strobe sample
	logic       msb_last;
	// High for one clock on a strobe rising edge
	logic       msb_rise;
	// Column register, upper five data bits
	logic [4:0] col;

	assign msb_rise = msb && !msb_last;

	// Strobe history, sampled every clock
	always_ff @(posedge clk)
	begin
		msb_last <= msb;
	end

	// Column load
	// New value shows on the address one clock after the edge
	always_ff @(posedge clk)
	begin
		if (reset)
			col <= 5'd0;
		else if (msb_rise)
			col <= cpu.data[7:3];
	end

	// Page address select
	// One select for all six bits, pure combinational path
	always_comb
	begin
		case (mode)
			// Straight CPU access, low half
			MODE_CPU_LO:
				ram_addr = cpu.addr[5:0];
			// Straight CPU access, high half
			MODE_CPU_HI:
				ram_addr = cpu.addr[11:6];
			// Character cell along the line
			// 8V on top, then 128H down to 8H
			MODE_HPOS:
				ram_addr = {timing.vcnt[3], timing.hcnt[7:3]};
			// Character row, 16V to 128V
			MODE_VPOS:
				ram_addr = {2'b00, timing.vcnt[7:4]};
			// Fetched code low bits with the line in cell
			MODE_DATA_LINE:
				ram_addr = {cpu.data[2:0], timing.vcnt[2:0]};
			// Latched column with the top bit forced
			MODE_COLUMN:
				ram_addr = {1'b1, col};
			// Unused codes park the bus at zero
			MODE_OFF6,
			MODE_OFF7:
				ram_addr = 6'd0;
			default:
				ram_addr = 6'd0;
		endcase
	end

endmodule

//--- src.f
design/vic_pkg.sv
design/video_timing.sv
design/vram_addr_mux.sv
design/vic_video.sv
verif/tb_vic_video.sv

//--- verif/tb_vic_video.sv
// ====================================================================
// Testbench for the video subsystem with raster reference model,
// assertion checks and per-test reporting
// ====================================================================

`timescale 1ns/1ps

module tb_vic_video
	import vic_pkg::*;
();

	// Raster limits of the default board
	localparam logic [8:0] H_LAST      = 9'd327;
	localparam logic [8:0] V_LAST      = 9'd262;
	localparam logic [8:0] H_LINE_STEP = 9'd272;
	localparam int         RST_CYCLES  = 16;
	// Clocks per line with src toggling every two clocks
	localparam int         LINE_CLKS   = 1312;
	localparam int         REPORT_MAX  = 20;

	logic        clk;
	logic        reset;
	logic        src = 1'b0;
	logic        msb;
	addr_mode_e  mode;
	cpu_bus_t    cpu;
	vic_timing_t timing;
	logic [5:0]  ram_addr;

	// Stimulus control
	logic src_run = 1'b0;
	logic src_tog = 1'b0;
	logic check_en = 1'b0;

	// Reference model state
	logic        src_q;
	logic        msb_q;
	logic [8:0]  m_h;
	logic [8:0]  m_v;
	logic        m_wrapped;
	logic [4:0]  m_col;
	logic        h_step;
	vic_timing_t exp_timing;
	logic [5:0]  exp_addr;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors = 0;

	vic_video i_vic_video (
		.clk      (clk),
		.reset    (reset),
		.src      (src),
		.msb      (msb),
		.mode     (mode),
		.cpu      (cpu),
		.timing   (timing),
		.ram_addr (ram_addr)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Horizontal step rule, 0 to 327 then wrap
	function automatic logic [8:0] next_h(input logic [8:0] h);
		return (h == H_LAST) ? 9'd0 : h + 9'd1;
	endfunction

	// Flags from the count windows
	// vblank at line 0 only once a frame has wrapped
	function automatic vic_timing_t expected_timing(input logic [8:0] h,
		input logic [8:0] v, input logic wrapped);
		vic_timing_t t;
		t.hcnt   = h;
		t.vcnt   = v;
		t.hblank = (h >= 9'd256) && (h <= 9'd327);
		t.hsync  = (h >= 9'd273) && (h <= 9'd304);
		t.vblank = ((v >= 9'd225) && (v <= 9'd262)) || ((v == 9'd0) && wrapped);
		t.vsync  = (v >= 9'd237) && (v <= 9'd240);
		return t;
	endfunction

	// Page address table per mode
	function automatic logic [5:0] expected_addr(input addr_mode_e m, input cpu_bus_t c,
		input vic_timing_t t, input logic [4:0] col);
		logic [5:0] a;
		case (m)
			MODE_CPU_LO:    a = c.addr[5:0];
			MODE_CPU_HI:    a = c.addr[11:6];
			MODE_HPOS:
				a = {t.vcnt[3], t.hcnt[7], t.hcnt[6], t.hcnt[5], t.hcnt[4], t.hcnt[3]};
			MODE_VPOS:      a = {1'b0, 1'b0, t.vcnt[7], t.vcnt[6], t.vcnt[5], t.vcnt[4]};
			MODE_DATA_LINE: a = {c.data[2], c.data[1], c.data[0], t.vcnt[2:0]};
			MODE_COLUMN:    a = {1'b1, col};
			default:        a = 6'd0;
		endcase
		return a;
	endfunction

	// Pixel strobe, toggles every two clocks once running
	always @(posedge clk)
	begin
		#1;
		if (src_run)
		begin
			src_tog = !src_tog;
			if (!src_tog)
				src = !src;
		end
	end

	// Reference model, same clock as the DUT registers
	always @(posedge clk)
	begin
		src_q <= src;
		msb_q <= msb;
		if (reset)
		begin
			m_h       <= 9'd1;
			m_v       <= 9'd0;
			m_wrapped <= 1'b0;
			m_col     <= 5'd0;
		end
		else
		begin
			if (!src && src_q)
			begin
				m_h <= next_h(m_h);
				// One line step per line, at sync start
				if (m_h == H_LINE_STEP)
				begin
					m_v <= (m_v == V_LAST) ? 9'd0 : m_v + 9'd1;
					if (m_v == V_LAST)
						m_wrapped <= 1'b1;
				end
			end
			if (msb && !msb_q)
				m_col <= cpu.data[7:3];
		end
	end

	assign h_step     = !src && src_q;
	assign exp_timing = expected_timing(m_h, m_v, m_wrapped);
	assign exp_addr   = expected_addr(mode, cpu, timing, m_col);

	// No strobe edge, no count change
	hcnt_holds: assert property (@(posedge clk) disable iff (reset)
		!h_step |=> $stable(timing.hcnt))
	else
	begin
		errors++;
		$display("MISMATCH timing.hcnt moved without a src edge, now 0x%0h", timing.hcnt);
	end

	// Exactly one step per edge
	hcnt_steps: assert property (@(posedge clk) disable iff (reset)
		h_step |=> timing.hcnt == next_h($past(timing.hcnt)))
	else
	begin
		errors++;
		$display("MISMATCH timing.hcnt after src edge: got 0x%0h", timing.hcnt);
	end

	// Mid-cycle compare against the model
	always @(negedge clk)
	begin
		if (check_en && !reset)
		begin
			assert (timing == exp_timing)
			else
			begin
				errors++;
				if (errors <= REPORT_MAX)
				begin
					$write("MISMATCH timing: got hcnt 0x%0h vcnt 0x%0h flags 0x%0h",
						timing.hcnt, timing.vcnt, timing[3:0]);
					$display(", expected hcnt 0x%0h vcnt 0x%0h flags 0x%0h",
						exp_timing.hcnt, exp_timing.vcnt, exp_timing[3:0]);
				end
			end
			assert (ram_addr == exp_addr)
			else
			begin
				errors++;
				if (errors <= REPORT_MAX)
					$display("MISMATCH ram_addr: got 0x%0h expected 0x%0h (mode 0x%0h)",
						ram_addr, exp_addr, mode);
			end
		end
	end

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors)
			$display("Test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("Test %s: failed, %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	// Count horizontal wraps seen on the DUT output
	task automatic wait_h_wraps(input int lines, input int limit);
		int seen;
		int cycles;
		logic [8:0] last_h;
		seen = 0;
		cycles = 0;
		last_h = timing.hcnt;
		while (seen < lines && cycles < limit)
		begin
			@(negedge clk);
			if (last_h == H_LAST && timing.hcnt == 9'd0)
				seen++;
			last_h = timing.hcnt;
			cycles++;
		end
		if (seen < lines)
		begin
			errors++;
			$display("Timeout: only %0d of %0d line wraps seen", seen, lines);
		end
	endtask

	task automatic wait_v_count(input logic [8:0] target, input int limit);
		int cycles;
		cycles = 0;
		while (timing.vcnt != target && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (timing.vcnt != target)
		begin
			errors++;
			$display("Timeout: vertical count never reached %0d", target);
		end
	endtask

	// Random modes, buses and msb levels
	task automatic random_mux(input int cycles);
		logic [31:0] rnd;
		for (int i = 0; i < cycles; i++)
		begin
			rnd = $urandom();
			@(posedge clk);
			#1;
			mode = addr_mode_e'(rnd[2:0]);
			msb  = rnd[3] & rnd[4];
			cpu  = rnd[31:12];
		end
	endtask

	task automatic check_column(input logic [7:0] data);
		assert (ram_addr == {1'b1, data[7:3]})
		else
		begin
			errors++;
			$display("MISMATCH ram_addr column: got 0x%0h expected 0x%0h",
				ram_addr, {1'b1, data[7:3]});
		end
	endtask

	// Load on msb rise, then hold through high and low phases
	task automatic column_latch(input int rounds);
		logic [31:0] rnd;
		logic [31:0] fill;
		logic [7:0] data;
		int gap;
		for (int r = 0; r < rounds; r++)
		begin
			rnd = $urandom();
			gap = int'({29'd0, rnd[2:0]}) + 1;
			@(posedge clk);
			#1;
			mode = MODE_COLUMN;
			msb  = 1'b0;
			repeat (gap)
			begin
				@(posedge clk);
				#1;
				fill = $urandom();
				cpu  = fill[19:0];
			end
			data = rnd[15:8];
			@(posedge clk);
			#1;
			msb = 1'b1;
			cpu.data = data;
			for (int k = 0; k < 6; k++)
			begin
				@(posedge clk);
				#1;
				fill = $urandom();
				cpu.data = fill[7:0];
				msb = (k < 3);
				@(negedge clk);
				check_column(data);
			end
			@(posedge clk);
			@(negedge clk);
			check_column(data);
		end
	endtask

	initial
	begin
		void'($urandom(70));
		reset = 1'b1;
		msb   = 1'b0;
		mode  = MODE_CPU_LO;
		cpu   = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset state of counters and flags
		@(negedge clk);
		assert (timing == 22'({9'd1, 9'd0, 4'd0}))
		else
		begin
			errors++;
			$display("MISMATCH timing after reset: got 0x%0h expected 0x%0h",
				timing, 22'({9'd1, 9'd0, 4'd0}));
		end
		end_test("reset_values");

		check_en = 1'b1;
		src_run  = 1'b1;
		wait_h_wraps(1, 2 * LINE_CLKS);
		end_test("hcount_step_wrap");

		wait_h_wraps(3, 4 * LINE_CLKS);
		end_test("hsync_hblank_lines");

		// Full frame, through the wrap and the line after it
		wait_v_count(V_LAST, 270 * LINE_CLKS);
		wait_v_count(9'd0, 2 * LINE_CLKS);
		wait_v_count(9'd1, 2 * LINE_CLKS);
		end_test("vertical_frame");

		// One full frame so every line and column bit moves
		random_mux(263 * LINE_CLKS);
		end_test("ram_addr_modes");

		column_latch(5);
		end_test("column_latch");

		check_en = 1'b0;
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
